// ==== hw/csr_issue_consts.svh ====
`ifndef CSR_ISSUE_CONSTS_SVH
`define CSR_ISSUE_CONSTS_SVH

`define RS_DEPTH 16 // Station entries.
`define TAG_W 8 // Physical register tag.
`define XLEN 32
`define INUM_W 32 // Instruction sequence number.
`define CSR_AW 12

// Machine-mode CSRs held by the unit.
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC 12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC 12'h341
`define CSR_MCAUSE 12'h342

`endif

// ==== hw/csr_issue_pkg.sv ====
`include "csr_issue_consts.svh"

package csr_issue_pkg;

  // Encoded as the low bits of funct3.
  // The immediate forms share these and set use_imm.
  typedef enum logic [1:0] {
    csr_rw = 2'b01, // Read-write.
    csr_rs = 2'b10, // Read-set.
    csr_rc = 2'b11 // Read-clear.
  } csr_op_e;

  // Station index and occupancy count.
  typedef logic [$clog2(`RS_DEPTH)-1:0] rs_ptr_t;

endpackage

// ==== hw/csr_wakeup.sv ====
`timescale 1ns/1ps
`include "csr_issue_consts.svh"

module csr_wakeup (
  input  logic [`TAG_W-1:0] src_tag,
  input  logic [`RS_DEPTH-1:0][`TAG_W-1:0] entry_tags,
  input  logic [`TAG_W-1:0] alu_tag,
  input  logic alu_valid,
  input  logic [`TAG_W-1:0] mul_tag,
  input  logic mul_valid,
  input  logic [`TAG_W-1:0] div_tag,
  input  logic div_valid,
  input  logic [`TAG_W-1:0] mem_tag,
  input  logic mem_read,
  input  logic [`TAG_W-1:0] br_tag,
  input  logic br_valid,
  input  logic [`TAG_W-1:0] p_tag,
  input  logic p_done,
  input  logic [`TAG_W-1:0] csr_tag,
  input  logic csr_done,
  output logic disp_hit,
  output logic [`RS_DEPTH-1:0] wake_vec
);

  localparam int NUM_BUS = 7;

  logic [NUM_BUS-1:0][`TAG_W-1:0] bus_tag;
  logic [NUM_BUS-1:0] bus_valid;

  assign bus_tag = {csr_tag, p_tag, br_tag, mem_tag, div_tag, mul_tag, alu_tag};
  assign bus_valid = {csr_done, p_done, br_valid, mem_read, div_valid, mul_valid, alu_valid};

  function automatic logic tag_hit(input logic [`TAG_W-1:0] tag);
    logic hit;
    hit = 1'b0;
    for (int b = 0; b < NUM_BUS; b++) begin
      hit = hit | (bus_valid[b] && (bus_tag[b] == tag));
    end
    return hit;
  endfunction

  always_comb begin
    disp_hit = tag_hit(src_tag);
    for (int e = 0; e < `RS_DEPTH; e++) begin
      wake_vec[e] = tag_hit(entry_tags[e]); // Entry state is checked in the station.
    end
  end

endmodule

// ==== hw/csr_rs.sv ====
`timescale 1ns/1ps
`include "csr_issue_consts.svh"

module csr_rs (
  input  logic clk,
  input  logic rst_n,
  input  logic flush,
  input  logic start,
  input  logic [`INUM_W-1:0] inst_num,
  input  logic [`TAG_W-1:0] rd,
  input  csr_issue_pkg::csr_op_e op,
  input  logic [`TAG_W-1:0] src_tag,
  input  logic src_valid,
  input  logic [`XLEN-1:0] imm,
  input  logic use_imm,
  input  logic [`CSR_AW-1:0] csr_addr,
  input  logic disp_hit,
  input  logic [`RS_DEPTH-1:0] wake_vec,
  output logic [`RS_DEPTH-1:0][`TAG_W-1:0] entry_tags,
  output logic rs_full,
  output logic issue_valid,
  output logic [`INUM_W-1:0] issue_inst_num,
  output logic [`TAG_W-1:0] issue_rd,
  output csr_issue_pkg::csr_op_e issue_op,
  output logic [`TAG_W-1:0] issue_src_tag,
  output logic [`XLEN-1:0] issue_imm,
  output logic issue_use_imm,
  output logic [`CSR_AW-1:0] issue_csr_addr
);

  import csr_issue_pkg::*;

  localparam rs_ptr_t LAST = rs_ptr_t'(`RS_DEPTH - 1);

  logic [`INUM_W-1:0] inst_num_q [`RS_DEPTH];
  logic [`TAG_W-1:0] rd_q [`RS_DEPTH];
  csr_op_e op_q [`RS_DEPTH];
  logic [`TAG_W-1:0] src_tag_q [`RS_DEPTH];
  logic [`XLEN-1:0] imm_q [`RS_DEPTH];
  logic use_imm_q [`RS_DEPTH];
  logic [`CSR_AW-1:0] csr_addr_q [`RS_DEPTH];
  logic [`RS_DEPTH-1:0] ready_q;

  rs_ptr_t head;
  rs_ptr_t tail;
  rs_ptr_t count; // Wraps to 0 when full, full_q tells the two apart.
  logic full_q;
  logic issue_valid_q;
  logic empty;
  logic push;
  logic pop;

  assign empty = (count == '0) && !full_q;
  assign push = start && !full_q && !flush; // Dropped while full.
  assign pop = !empty && ready_q[head]; // Oldest only, CSR ops serialize.

  assign rs_full = full_q;
  assign issue_valid = issue_valid_q && !flush;

  always_comb begin
    for (int e = 0; e < `RS_DEPTH; e++) begin
      entry_tags[e] = src_tag_q[e];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      full_q <= 1'b0;
      issue_valid_q <= 1'b0;
      ready_q <= '0;
    end else begin
      ready_q <= ready_q | wake_vec;
      if (push) begin
        tail <= tail + 1'b1;
        ready_q[tail] <= src_valid | disp_hit; // Overrides the wakeup OR for a new entry.
      end
      if (pop) begin
        head <= head + 1'b1;
      end
      issue_valid_q <= pop;
      case ({push, pop})
        2'b10: begin
          count <= count + 1'b1;
          full_q <= (count == LAST);
        end
        2'b01: begin
          count <= count - 1'b1;
          full_q <= 1'b0;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      inst_num_q[tail] <= inst_num;
      rd_q[tail] <= rd;
      op_q[tail] <= op;
      src_tag_q[tail] <= src_tag;
      imm_q[tail] <= imm;
      use_imm_q[tail] <= use_imm;
      csr_addr_q[tail] <= csr_addr;
    end
    if (pop) begin
      issue_inst_num <= inst_num_q[head];
      issue_rd <= rd_q[head];
      issue_op <= op_q[head];
      issue_src_tag <= src_tag_q[head];
      issue_imm <= imm_q[head];
      issue_use_imm <= use_imm_q[head];
      issue_csr_addr <= csr_addr_q[head];
    end
  end

endmodule

// ==== hw/csr_unit.sv ====
`timescale 1ns/1ps
`include "csr_issue_consts.svh"

module csr_unit (
  input  logic clk,
  input  logic rst_n,
  input  logic issue_valid,
  input  logic [`INUM_W-1:0] issue_inst_num,
  input  logic [`TAG_W-1:0] issue_rd,
  input  csr_issue_pkg::csr_op_e issue_op,
  input  logic [`TAG_W-1:0] issue_src_tag,
  input  logic [`XLEN-1:0] issue_imm,
  input  logic issue_use_imm,
  input  logic [`CSR_AW-1:0] issue_csr_addr,
  input  logic [`XLEN-1:0] prf_rdata,
  output logic [`TAG_W-1:0] prf_raddr,
  output logic done,
  output logic [`TAG_W-1:0] done_tag,
  output logic [`XLEN-1:0] done_data,
  output logic [`INUM_W-1:0] done_inst_num
);

  import csr_issue_pkg::*;

  logic [`XLEN-1:0] mstatus;
  logic [`XLEN-1:0] mtvec;
  logic [`XLEN-1:0] mscratch;
  logic [`XLEN-1:0] mepc;
  logic [`XLEN-1:0] mcause;
  logic [`XLEN-1:0] operand;
  logic [`XLEN-1:0] old_val;
  logic [`XLEN-1:0] new_val;

  assign prf_raddr = issue_src_tag; // Read port answers in the same cycle.
  assign operand = issue_use_imm ? issue_imm : prf_rdata;

  always_comb begin
    case (issue_csr_addr)
      `CSR_MSTATUS: old_val = mstatus;
      `CSR_MTVEC: old_val = mtvec;
      `CSR_MSCRATCH: old_val = mscratch;
      `CSR_MEPC: old_val = mepc;
      `CSR_MCAUSE: old_val = mcause;
      default: old_val = '0; // Unimplemented CSR reads as zero.
    endcase
  end

  always_comb begin
    case (issue_op)
      csr_rw: new_val = operand;
      csr_rs: new_val = old_val | operand;
      csr_rc: new_val = old_val & ~operand;
      default: new_val = old_val;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mstatus <= '0;
      mtvec <= '0;
      mscratch <= '0;
      mepc <= '0;
      mcause <= '0;
    end else if (issue_valid) begin
      case (issue_csr_addr)
        `CSR_MSTATUS: mstatus <= new_val;
        `CSR_MTVEC: mtvec <= new_val;
        `CSR_MSCRATCH: mscratch <= new_val;
        `CSR_MEPC: mepc <= new_val;
        `CSR_MCAUSE: mcause <= new_val;
        default: ; // Write to an unknown address is dropped.
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else begin
      done <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      done_tag <= issue_rd;
      done_data <= old_val; // Old value goes to rd.
      done_inst_num <= issue_inst_num;
    end
  end

endmodule

// ==== hw/csr_issue.sv ====
`timescale 1ns/1ps
`include "csr_issue_consts.svh"

module csr_issue (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  input  logic [`INUM_W-1:0] inst_num,
  input  logic [`TAG_W-1:0] rd,
  input  csr_issue_pkg::csr_op_e op,
  input  logic [`TAG_W-1:0] src_tag,
  input  logic src_valid,
  input  logic [`XLEN-1:0] imm,
  input  logic use_imm,
  input  logic [`CSR_AW-1:0] csr_addr,
  output logic rs_full,
  input  logic [`TAG_W-1:0] alu_tag,
  input  logic alu_valid,
  input  logic [`TAG_W-1:0] mul_tag,
  input  logic mul_valid,
  input  logic [`TAG_W-1:0] div_tag,
  input  logic div_valid,
  input  logic [`TAG_W-1:0] mem_tag,
  input  logic mem_read,
  input  logic [`TAG_W-1:0] br_tag,
  input  logic br_valid,
  input  logic [`TAG_W-1:0] p_tag,
  input  logic p_done,
  input  logic exception_sig,
  input  logic mret_sig,
  output logic [`TAG_W-1:0] prf_raddr,
  input  logic [`XLEN-1:0] prf_rdata,
  output logic done,
  output logic [`TAG_W-1:0] done_tag,
  output logic [`XLEN-1:0] done_data,
  output logic [`INUM_W-1:0] done_inst_num
);

  import csr_issue_pkg::*;

  logic disp_hit;
  logic [`RS_DEPTH-1:0] wake_vec;
  logic [`RS_DEPTH-1:0][`TAG_W-1:0] entry_tags;
  logic issue_valid;
  logic [`INUM_W-1:0] issue_inst_num;
  logic [`TAG_W-1:0] issue_rd;
  csr_op_e issue_op;
  logic [`TAG_W-1:0] issue_src_tag;
  logic [`XLEN-1:0] issue_imm;
  logic issue_use_imm;
  logic [`CSR_AW-1:0] issue_csr_addr;

  csr_wakeup u_wakeup (
    .src_tag    (src_tag),
    .entry_tags (entry_tags),
    .alu_tag    (alu_tag),
    .alu_valid  (alu_valid),
    .mul_tag    (mul_tag),
    .mul_valid  (mul_valid),
    .div_tag    (div_tag),
    .div_valid  (div_valid),
    .mem_tag    (mem_tag),
    .mem_read   (mem_read),
    .br_tag     (br_tag),
    .br_valid   (br_valid),
    .p_tag      (p_tag),
    .p_done     (p_done),
    .csr_tag    (done_tag), // Own completion wakes dependents.
    .csr_done   (done),
    .disp_hit   (disp_hit),
    .wake_vec   (wake_vec)
  );

  csr_rs u_rs (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (exception_sig | mret_sig),
    .start          (start),
    .inst_num       (inst_num),
    .rd             (rd),
    .op             (op),
    .src_tag        (src_tag),
    .src_valid      (src_valid),
    .imm            (imm),
    .use_imm        (use_imm),
    .csr_addr       (csr_addr),
    .disp_hit       (disp_hit),
    .wake_vec       (wake_vec),
    .entry_tags     (entry_tags),
    .rs_full        (rs_full),
    .issue_valid    (issue_valid),
    .issue_inst_num (issue_inst_num),
    .issue_rd       (issue_rd),
    .issue_op       (issue_op),
    .issue_src_tag  (issue_src_tag),
    .issue_imm      (issue_imm),
    .issue_use_imm  (issue_use_imm),
    .issue_csr_addr (issue_csr_addr)
  );

  csr_unit u_unit (
    .clk            (clk),
    .rst_n          (rst_n),
    .issue_valid    (issue_valid),
    .issue_inst_num (issue_inst_num),
    .issue_rd       (issue_rd),
    .issue_op       (issue_op),
    .issue_src_tag  (issue_src_tag),
    .issue_imm      (issue_imm),
    .issue_use_imm  (issue_use_imm),
    .issue_csr_addr (issue_csr_addr),
    .prf_rdata      (prf_rdata),
    .prf_raddr      (prf_raddr),
    .done           (done),
    .done_tag       (done_tag),
    .done_data      (done_data),
    .done_inst_num  (done_inst_num)
  );

endmodule

// ==== verif/csr_issue_properties.sv ====
`timescale 1ns/1ps

module csr_issue_properties (
  input logic clk,
  input logic rst_n,
  input logic issue_valid,
  input logic done,
  input logic exception_sig,
  input logic mret_sig
);

  // The unit registers every issue into exactly one completion.
  done_after_issue: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid |=> done)
    else $error("issue_valid was not followed by done one cycle later");

  done_has_issue: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> $past(issue_valid))
    else $error("done without issue_valid in the previous cycle");

  flush_kills_issue: assert property (@(posedge clk) disable iff (!rst_n)
    (exception_sig || mret_sig) |=> !issue_valid)
    else $error("issue_valid high in the cycle after a flush");

  // Back-to-back completions need back-to-back issues.
  done_pair_issues: assert property (@(posedge clk) disable iff (!rst_n)
    (done && $past(done)) |-> ($past(issue_valid, 1) && $past(issue_valid, 2)))
    else $error("two done pulses in a row without two issues");

endmodule

bind csr_issue csr_issue_properties u_props (
  .clk           (clk),
  .rst_n         (rst_n),
  .issue_valid   (issue_valid),
  .done          (done),
  .exception_sig (exception_sig),
  .mret_sig      (mret_sig)
);

// ==== verif/tb_csr_issue.sv ====
`timescale 1ns/1ps
`include "csr_issue_consts.svh"

module tb_csr_issue;

  import csr_issue_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_DISPATCH = 80; // Dispatches in the sequence below, rounded up.
  localparam int WATCHDOG_CYCLES = NUM_DISPATCH * 40;

  typedef struct packed {
    logic [`INUM_W-1:0] inum;
    logic [`TAG_W-1:0] rd;
    csr_op_e op;
    logic [`TAG_W-1:0] src;
    logic [`XLEN-1:0] imm;
    logic use_imm;
    logic [`CSR_AW-1:0] addr;
  } disp_t;

  logic clk;
  logic rst_n;
  logic start;
  logic [`INUM_W-1:0] inst_num;
  logic [`TAG_W-1:0] rd;
  csr_op_e op;
  logic [`TAG_W-1:0] src_tag;
  logic src_valid;
  logic [`XLEN-1:0] imm;
  logic use_imm;
  logic [`CSR_AW-1:0] csr_addr;
  logic rs_full;
  logic [`TAG_W-1:0] bus_tag [6]; // ALU, MUL, DIV, MEM, BR, P.
  logic [5:0] bus_vld;
  logic exception_sig;
  logic mret_sig;
  logic [`TAG_W-1:0] prf_raddr;
  logic [`XLEN-1:0] prf_rdata;
  logic done;
  logic [`TAG_W-1:0] done_tag;
  logic [`XLEN-1:0] done_data;
  logic [`INUM_W-1:0] done_inst_num;

  logic [`XLEN-1:0] prf_mem [1 << `TAG_W]; // What the DUT reads.
  logic [`XLEN-1:0] tag_val [1 << `TAG_W]; // Value a tag carries once produced.
  logic [`XLEN-1:0] model_csr [1 << `CSR_AW];
  disp_t pending [$];
  logic [31:0] rng;
  logic [`INUM_W-1:0] next_inum;
  logic [`TAG_W-1:0] next_rd;

  csr_issue dut_i (
    .alu_tag   (bus_tag[0]),
    .alu_valid (bus_vld[0]),
    .mul_tag   (bus_tag[1]),
    .mul_valid (bus_vld[1]),
    .div_tag   (bus_tag[2]),
    .div_valid (bus_vld[2]),
    .mem_tag   (bus_tag[3]),
    .mem_read  (bus_vld[3]),
    .br_tag    (bus_tag[4]),
    .br_valid  (bus_vld[4]),
    .p_tag     (bus_tag[5]),
    .p_done    (bus_vld[5]),
    .*
  );

  assign prf_rdata = prf_mem[prf_raddr];

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic csr_op_e op_by_index(input int i);
    case (i)
      0: return csr_rw;
      1: return csr_rs;
      default: return csr_rc;
    endcase
  endfunction

  function automatic logic [`CSR_AW-1:0] addr_by_index(input int i);
    case (i)
      0: return `CSR_MSTATUS;
      1: return `CSR_MTVEC;
      2: return `CSR_MSCRATCH;
      3: return `CSR_MEPC;
      default: return `CSR_MCAUSE;
    endcase
  endfunction

  // Machine-mode CSR rule, returns the value rd receives.
  function automatic logic [`XLEN-1:0] csr_ref(input csr_op_e f_op,
      input logic [`CSR_AW-1:0] f_addr, input logic [`XLEN-1:0] operand);
    logic [`XLEN-1:0] old_val;
    logic known;
    known = (f_addr == `CSR_MSTATUS) || (f_addr == `CSR_MTVEC) ||
            (f_addr == `CSR_MSCRATCH) || (f_addr == `CSR_MEPC) || (f_addr == `CSR_MCAUSE);
    old_val = known ? model_csr[f_addr] : '0;
    if (known) begin
      case (f_op)
        csr_rw: model_csr[f_addr] = operand;
        csr_rs: model_csr[f_addr] = old_val | operand;
        default: model_csr[f_addr] = old_val & ~operand;
      endcase
    end
    return old_val;
  endfunction

  task automatic check(input string what, input logic [`XLEN-1:0] got,
      input logic [`XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic set_reg(input logic [`TAG_W-1:0] tag, input logic [`XLEN-1:0] value);
    tag_val[tag] = value;
    prf_mem[tag] = value;
  endtask

  task automatic drive_bus(input int bus, input logic [`TAG_W-1:0] tag, input logic on);
    if (on) begin
      prf_mem[tag] = tag_val[tag]; // Value lands with its broadcast.
    end
    bus_tag[bus] = tag;
    bus_vld[bus] = on;
  endtask

  task automatic broadcast(input int bus, input logic [`TAG_W-1:0] tag);
    drive_bus(bus, tag, 1'b1);
    @(posedge clk);
    #2;
    drive_bus(bus, tag, 1'b0);
  endtask

  task automatic dispatch(input csr_op_e d_op, input logic [`CSR_AW-1:0] d_addr,
      input logic [`TAG_W-1:0] d_src, input logic d_ready, input logic d_use_imm,
      input logic [`XLEN-1:0] d_imm, input logic accept);
    disp_t d;
    d = '{inum: next_inum, rd: next_rd, op: d_op, src: d_src, imm: d_imm,
          use_imm: d_use_imm, addr: d_addr};
    start = 1'b1;
    inst_num = next_inum;
    rd = next_rd;
    op = d_op;
    src_tag = d_src;
    src_valid = d_ready;
    imm = d_imm;
    use_imm = d_use_imm;
    csr_addr = d_addr;
    if (accept) begin
      pending.push_back(d);
    end
    next_inum++;
    next_rd++;
    @(posedge clk);
    #2;
    start = 1'b0;
  endtask

  task automatic drain();
    while (pending.size() != 0) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic expect_quiet(input int cycles, input string what);
    repeat (cycles) begin
      check(what, done, 0);
      @(posedge clk);
      #2;
    end
  endtask

  task automatic read_all();
    for (int a = 0; a < 5; a++) begin
      dispatch(csr_rs, addr_by_index(a), 8'h00, 1'b1, 1'b1, '0, 1'b1); // Set with 0 only reads.
    end
    drain();
  endtask

  // Each done retires the oldest outstanding dispatch.
  always @(posedge clk) begin
    disp_t d;
    logic [`XLEN-1:0] operand;
    logic [`XLEN-1:0] exp_old;
    if (rst_n && done) begin
      if (pending.size() == 0) begin
        $display("Done for instruction %0d arrived with nothing outstanding", done_inst_num);
        $display("Test failures found");
        $fatal(1);
      end else begin
        d = pending.pop_front();
        operand = d.use_imm ? d.imm : tag_val[d.src];
        exp_old = csr_ref(d.op, d.addr, operand);
        check("done_data", done_data, exp_old);
        check("done_tag", done_tag, d.rd);
        check("done_inst_num", done_inst_num, d.inum);
        tag_val[d.rd] = exp_old;
        prf_mem[done_tag] = done_data; // Register file write-back.
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d cycles, the DUT stopped completing operations", WATCHDOG_CYCLES);
    $display("Test failures found");
    $fatal(1);
  end

  initial begin
    logic [`TAG_W-1:0] t;
    logic [`TAG_W-1:0] prod;
    clk = 1'b0;
    rst_n = 1'b0;
    start = 1'b0;
    inst_num = '0;
    rd = '0;
    op = csr_rw;
    src_tag = '0;
    src_valid = 1'b0;
    imm = '0;
    use_imm = 1'b0;
    csr_addr = '0;
    bus_vld = '0;
    exception_sig = 1'b0;
    mret_sig = 1'b0;
    rng = 32'hc41a;
    next_inum = 32'd1;
    next_rd = 8'h80;
    for (int i = 0; i < 6; i++) begin
      bus_tag[i] = '0;
    end
    for (int i = 0; i < (1 << `TAG_W); i++) begin
      prf_mem[i] = {4{8'(i)}} ^ 32'hdead_beef; // Stale contents until produced.
      tag_val[i] = '0;
    end
    for (int i = 0; i < (1 << `CSR_AW); i++) begin
      model_csr[i] = '0;
    end
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check("rs_full after reset", rs_full, 0);
    check("done after reset", done, 0);

    // Lone ready op, done two edges after the start edge.
    set_reg(8'h01, next_rand());
    dispatch(csr_rw, `CSR_MSCRATCH, 8'h01, 1'b1, 1'b0, '0, 1'b1);
    expect_quiet(2, "done before its latency");
    check("done two cycles after start", done, 1);
    drain();

    for (int i = 0; i < 15; i++) begin
      set_reg(8'(i + 1), next_rand());
      dispatch(op_by_index(i / 5), addr_by_index(i % 5), 8'(i + 1), 1'b1, 1'b0, '0, 1'b1);
    end
    drain();

    // Wakeup from each external bus, then from the unit's own completion.
    for (int k = 0; k < 6; k++) begin
      t = 8'h10 + 8'(k);
      tag_val[t] = next_rand();
      dispatch(op_by_index(k % 3), addr_by_index(k % 5), t, 1'b0, 1'b0, '0, 1'b1);
      expect_quiet(5, "done before source broadcast");
      broadcast(k, t);
      drain();
    end
    set_reg(8'h01, next_rand());
    prod = next_rd;
    dispatch(csr_rs, `CSR_MSCRATCH, 8'h01, 1'b1, 1'b0, '0, 1'b1);
    dispatch(csr_rw, `CSR_MEPC, prod, 1'b0, 1'b0, '0, 1'b1);
    drain();

    // Broadcast in the dispatch cycle.
    for (int k = 0; k < 6; k += 2) begin
      t = 8'h18 + 8'(k);
      tag_val[t] = next_rand();
      drive_bus(k, t, 1'b1);
      dispatch(op_by_index(k / 2), addr_by_index(k / 2 + 1), t, 1'b0, 1'b0, '0, 1'b1);
      drive_bus(k, t, 1'b0);
      drain();
    end

    // Immediate forms, then an unimplemented address.
    for (int k = 0; k < 3; k++) begin
      dispatch(op_by_index(k), addr_by_index(k + 2), 8'h05, 1'b1, 1'b1, next_rand(), 1'b1);
    end
    for (int k = 0; k < 3; k++) begin
      set_reg(8'(k + 6), next_rand());
      dispatch(op_by_index(k), 12'h7c0, 8'(k + 6), 1'b1, 1'b0, '0, 1'b1);
    end
    read_all();

    // Fill the station behind one blocking tag.
    tag_val[8'h20] = next_rand();
    for (int i = 0; i < `RS_DEPTH; i++) begin
      check("rs_full while filling", rs_full, 0);
      dispatch(op_by_index(i % 3), addr_by_index(i % 5), 8'h20, 1'b0, 1'b0, '0, 1'b1);
    end
    check("rs_full with all entries stalled", rs_full, 1);
    dispatch(csr_rw, `CSR_MTVEC, 8'h00, 1'b1, 1'b0, '0, 1'b0);
    check("rs_full after dropped start", rs_full, 1);
    expect_quiet(3, "done while the station is stalled");
    broadcast(3, 8'h20);
    drain();
    expect_quiet(4, "done for a dropped start");

    // Exception flush, then mret flush.
    for (int f = 0; f < 2; f++) begin
      t = 8'h30 + 8'(f);
      tag_val[t] = next_rand();
      for (int i = 0; i < 4; i++) begin
        dispatch(op_by_index(i % 3), addr_by_index(i), t, 1'b0, 1'b0, '0, 1'b1);
      end
      broadcast(f + 1, t); // Head issues in the flush cycle.
      @(posedge clk);
      #2;
      if (f == 0) begin
        exception_sig = 1'b1;
      end else begin
        mret_sig = 1'b1;
      end
      @(posedge clk);
      #2;
      exception_sig = 1'b0;
      mret_sig = 1'b0;
      pending.delete(); // Discarded entries never reach the model.
      broadcast(f + 1, t);
      expect_quiet(6, "done for a flushed entry");
      read_all();
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== csr_issue.f ====
+incdir+hw
hw/csr_issue_pkg.sv
hw/csr_wakeup.sv
hw/csr_rs.sv
hw/csr_unit.sv
hw/csr_issue.sv
verif/csr_issue_properties.sv
verif/tb_csr_issue.sv

// ==== Bender.yml ====
package:
  name: csr_issue

sources:
  - include_dirs:
      - hw
    files:
      - hw/csr_issue_pkg.sv
      - hw/csr_wakeup.sv
      - hw/csr_rs.sv
      - hw/csr_unit.sv
      - hw/csr_issue.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verif/csr_issue_properties.sv
      - verif/tb_csr_issue.sv
